// File: Makefile
# Verilator build and run for the softmax engine

SRCS := $(filter-out +%,$(shell cat list.f))

obj_dir/Vsoftmax_tb: list.f $(SRCS) hw/softmax_settings.svh
	verilator --binary --timing -Wno-fatal -j 0 -f list.f \
		--top-module softmax_tb -o Vsoftmax_tb

.PHONY: run clean

run: obj_dir/Vsoftmax_tb
	@out=$$(obj_dir/Vsoftmax_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Regression passed'

clean:
	rm -rf obj_dir

// File: bench/softmax_tb.sv
// ******************************
// testbench for softmax_top
// stimulus, reference model,
// output checker, final report
// ******************************

`include "softmax_settings.svh"

module softmax_tb import softmax_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RUNS   = 7;
    // load, max pass, exp pass, divide pass, slack
    localparam int RUN_CYCLES = `SM_N + (`SM_N + 2) + (`SM_N + 5)
                                + `SM_N * `SM_DIV_CYCLES + 16;
    localparam int CYCLE_LIMIT = (NUM_RUNS + 1) * RUN_CYCLES;

    logic    clk;
    logic    rst;
    logic    load_en;
    addr_t   load_addr;
    sample_t load_data;
    logic    start;
    logic    busy;
    logic    out_valid;
    addr_t   out_index;
    prob_t   out_prob;
    logic    done;

    int batch [`SM_N];
    int expected [`SM_N];
    int out_count;
    int next_index;
    int done_count;
    bit done_seen;
    bit in_run;
    int test_errs;
    int pass_count;
    int fail_count;
    int cycles = 0;

    softmax_top i_softmax_top (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .busy      (busy),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_prob  (out_prob),
        .done      (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no done after %0d cycles, the run is stuck", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // e(d) = round(65535 * exp(-d/16))
    function automatic int exp_ref(input int d);
        return $rtoi(65535.0 * $exp(-real'(d) / 16.0) + 0.5);
    endfunction

    function automatic void ref_softmax();
        int     mx;
        int     d;
        int     e [`SM_N];
        longint s;
        longint p;
        mx = batch[0];
        s  = 0;
        for (int i = 1; i < `SM_N; i++) begin
            if (batch[i] > mx) mx = batch[i];
        end
        for (int i = 0; i < `SM_N; i++) begin
            d = mx - batch[i];
            if (d > 255) d = 255;          // clamp
            e[i] = exp_ref(d);
            s += e[i];
        end
        for (int i = 0; i < `SM_N; i++) begin
            p = (longint'(e[i]) * 65536) / s;
            if (p > 65535) p = 65535;      // saturate
            expected[i] = int'(p);
        end
    endfunction

    // compare outputs away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            if (in_run && !busy) begin
                $display("busy dropped before done at %0t", $time);
                test_errs++;
            end
            if (out_valid) begin
                if (int'(out_index) != next_index) begin
                    $display("output index %0d arrived out of order, index %0d was due",
                             out_index, next_index);
                    test_errs++;
                end
                if (int'(out_prob) != expected[out_index]) begin
                    $display("** Error at %0t: index %0d expected %0d got %0d",
                             $time, out_index, expected[out_index], out_prob);
                    test_errs++;
                end
                if (done && int'(out_index) != `SM_N - 1) begin
                    $display("done came with index %0d instead of the last one", out_index);
                    test_errs++;
                end
                next_index = int'(out_index) + 1;
                out_count++;
            end
            if (done) begin
                if (!out_valid) begin
                    $display("done came without an output at %0t", $time);
                    test_errs++;
                end
                done_count++;
                done_seen = 1'b1;
                in_run    = 1'b0;
            end
        end
    end

    task automatic write_batch();
        for (int i = 0; i < `SM_N; i++) begin
            @(posedge clk);
            #2;
            load_en   = 1'b1;
            load_addr = addr_t'(i);
            load_data = sample_t'(batch[i]);
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    task automatic run_batch(input string name, input bit extra_start);
        while (busy) @(posedge clk);
        write_batch();
        ref_softmax();
        test_errs  = 0;
        out_count  = 0;
        next_index = 0;
        done_count = 0;
        done_seen  = 1'b0;
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start  = 1'b0;
        in_run = 1'b1;
        if (extra_start) begin
            while (out_count < `SM_N - 2) @(posedge clk);   // a stray batch would outlive done
            #2;
            start = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        while (!done_seen) @(posedge clk);
        repeat (4) @(posedge clk);
        if (out_count != `SM_N) begin
            $display("%s: saw %0d outputs instead of %0d", name, out_count, `SM_N);
            test_errs++;
        end
        if (done_count != 1) begin
            $display("%s: saw %0d done pulses instead of one", name, done_count);
            test_errs++;
        end
        if (busy) begin
            $display("%s: busy still high after done, a second run started", name);
            test_errs++;
        end
        if (test_errs == 0) pass_count++;
        else fail_count++;
        $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        in_run     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'hb595));
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle outputs straight out of reset
        if (busy || out_valid) begin
            $display("busy or out_valid high right after reset");
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("test reset_state: %s", (busy || out_valid) ? "FAILED" : "ok");

        for (int i = 0; i < `SM_N; i++) batch[i] = i - 32;
        run_batch("ramp", 1'b0);
        for (int i = 0; i < `SM_N; i++) batch[i] = 5;
        run_batch("all_equal", 1'b0);   // 1024 each
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < `SM_N; i++) batch[i] = int'($urandom_range(255)) - 128;
            run_batch($sformatf("random_%0d", r), 1'b0);
        end
        for (int i = 0; i < `SM_N; i++) batch[i] = -128;
        batch[17] = 127;
        run_batch("wide_spread", 1'b0);
        for (int i = 0; i < `SM_N; i++) batch[i] = int'($urandom_range(255)) - 128;
        run_batch("start_while_busy", 1'b1);

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: hw/exp_table.sv
// ******************************
// e^-d lookup, two cycle pipe
// 256 entry ROM, Q0.16 output
// ******************************

`include "softmax_settings.svh"

module exp_table import softmax_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] diff,
    output exp_t       exp_out
);

    exp_t       rom [256];
    logic [7:0] idx_q;

    // round(65535 * exp(-d / 2^DFRAC))
    function automatic exp_t exp_entry(input int d);
        real v;
        v = 65535.0 * $exp(-real'(d) / real'(1 << `SM_DFRAC));
        return exp_t'($rtoi(v + 0.5));
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = exp_entry(i);
        end
    end

    // stage 1 index, stage 2 ROM data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx_q   <= '0;
            exp_out <= '0;
        end else begin
            idx_q   <= diff;
            exp_out <= rom[idx_q];
        end
    end

endmodule

// File: hw/max_scan.sv
// ******************************
// pass 1 of the softmax engine
// scans samples, finds batch max
// ******************************

`include "softmax_settings.svh"

module max_scan import softmax_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    pipe_busy,
    output addr_t   scan_addr,
    input  sample_t scan_data,
    output logic    active,
    output logic    max_valid,
    output sample_t max_value
);

    localparam addr_t LAST_ADDR = addr_t'(`SM_N - 1);

    logic  running;
    addr_t cnt;
    logic  rd_valid;     // scan_data holds a sample this cycle
    logic  rd_first;
    logic  rd_last;
    logic  idle;
    logic  accept;

    assign idle      = ~(running | rd_valid | max_valid);
    assign accept    = start & idle & ~pipe_busy;   // new batch only with whole pipe free
    assign active    = accept | ~idle;
    assign scan_addr = cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            cnt       <= '0;
            rd_valid  <= 1'b0;
            rd_first  <= 1'b0;
            rd_last   <= 1'b0;
            max_valid <= 1'b0;
        end else begin
            rd_valid  <= running;
            rd_first  <= running && (cnt == '0);
            rd_last   <= running && (cnt == LAST_ADDR);
            max_valid <= rd_valid & rd_last;
            if (accept) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;          // wraps back to 0 after the last one
                if (cnt == LAST_ADDR) begin
                    running <= 1'b0;
                end
            end
        end
    end

    // running max, seeded by sample 0
    always_ff @(posedge clk) begin
        if (rd_valid && (rd_first || scan_data > max_value)) begin
            max_value <= scan_data;
        end
    end

endmodule

// File: hw/norm_exp_sum.sv
// ******************************
// pass 2 of the softmax engine
// max minus x, e^-d, store, sum
// ******************************

`include "softmax_settings.svh"

module norm_exp_sum import softmax_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    max_valid,
    input  sample_t max_value,
    output addr_t   rd_addr,
    input  sample_t rd_data,
    output logic    wr_en,
    output addr_t   wr_addr,
    output exp_t    wr_data,
    output logic    active,
    output logic    sum_valid,
    output sum_t    sum_value
);

    localparam int    DEPTH     = 4;    // memory, clamp reg, two table stages
    localparam addr_t LAST_ADDR = addr_t'(`SM_N - 1);

    logic                     running;
    addr_t                    cnt;
    sample_t                  max_q;
    logic signed [`SM_XW+1:0] diff_full;
    logic [7:0]               diff_clamp;
    logic [7:0]               diff_q;
    logic [DEPTH-1:0]         v_sh;
    addr_t                    addr_sh [DEPTH];
    exp_t                     exp_val;
    sum_t                     acc;

    assign rd_addr   = cnt;
    assign diff_full = max_q - rd_data;

    always_comb begin
        if (diff_full > 10'sd255) begin
            diff_clamp = 8'hff;
        end else if (diff_full < 10'sd0) begin
            diff_clamp = 8'h00;             // cannot happen with a true max
        end else begin
            diff_clamp = diff_full[7:0];
        end
    end

    exp_table u_exp_table (
        .clk     (clk),
        .rst     (rst),
        .diff    (diff_q),
        .exp_out (exp_val)
    );

    // write port sits at the end of the shift line
    assign wr_en     = v_sh[DEPTH-1];
    assign wr_addr   = addr_sh[DEPTH-1];
    assign wr_data   = exp_val;
    assign sum_value = acc;
    assign active    = running | (|v_sh) | sum_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            cnt       <= '0;
            v_sh      <= '0;
            acc       <= '0;
            sum_valid <= 1'b0;
        end else begin
            v_sh      <= {v_sh[DEPTH-2:0], running};
            sum_valid <= v_sh[DEPTH-1] && (addr_sh[DEPTH-1] == LAST_ADDR);
            if (max_valid) begin
                running <= 1'b1;
                cnt     <= '0;
                acc     <= '0;
            end else begin
                if (running) begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_ADDR) begin
                        running <= 1'b0;
                    end
                end
                if (v_sh[DEPTH-1]) begin
                    acc <= acc + sum_t'(exp_val);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (max_valid) begin
            max_q <= max_value;
        end
        diff_q     <= diff_clamp;
        addr_sh[0] <= cnt;
        for (int i = 1; i < DEPTH; i++) begin
            addr_sh[i] <= addr_sh[i-1];
        end
    end

endmodule

// File: hw/sample_ram.sv
// ******************************
// register array memory
// one write port, two read ports
// ******************************

`include "softmax_settings.svh"

module sample_ram (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [`SM_AW-1:0] wr_addr,
    input  logic [`SM_EW-1:0] wr_data,
    input  logic [`SM_AW-1:0] rd_addr_a,
    output logic [`SM_EW-1:0] rd_data_a,
    input  logic [`SM_AW-1:0] rd_addr_b,
    output logic [`SM_EW-1:0] rd_data_b
);

    logic [`SM_EW-1:0] mem [`SM_N];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // both reads land one cycle later
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

endmodule

// File: hw/scale_div.sv
// ******************************
// pass 3 of the softmax engine
// e * 65536 / S per element
// ******************************

`include "softmax_settings.svh"

module scale_div import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  sum_valid,
    input  sum_t  sum_value,
    output addr_t rd_addr,
    input  exp_t  rd_data,
    output logic  active,
    output logic  out_valid,
    output addr_t out_index,
    output prob_t out_prob,
    output logic  done
);

    localparam int                STEP_W    = $clog2(`SM_DIV_CYCLES);
    localparam logic [STEP_W-1:0] STEP_LOAD = STEP_W'(1);
    localparam logic [STEP_W-1:0] STEP_EMIT = STEP_W'(`SM_DIV_CYCLES - 1);

    logic              running;
    logic [STEP_W-1:0] step;       // 0 read, 1..16 quotient, 17 emit
    addr_t             idx;
    logic              last_elem;
    sum_t              divisor;
    sum_t              rem;
    sum_t              rem_in;
    logic [`SM_SW:0]   rem_sh;
    sum_t              rem_next;
    logic              q_bit;
    prob_t             quo;
    logic              ovf;        // e >= S, quotient would be 65536

    assign rd_addr   = idx;        // idle at 0, so element 0 is read on sum_valid
    assign last_elem = (idx == addr_t'(`SM_N - 1));
    assign active    = running | out_valid;

    always_comb begin
        rem_in   = (step == STEP_LOAD) ? sum_t'(rd_data) : rem;
        rem_sh   = {rem_in, 1'b0};
        q_bit    = (rem_sh >= {1'b0, divisor});
        rem_next = q_bit ? sum_t'(rem_sh - {1'b0, divisor}) : sum_t'(rem_sh);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            step      <= '0;
            idx       <= '0;
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            done      <= 1'b0;
            if (!running) begin
                if (sum_valid) begin
                    running <= 1'b1;
                    step    <= STEP_LOAD;
                end
            end else if (step == STEP_EMIT) begin
                out_valid <= 1'b1;
                done      <= last_elem;
                step      <= '0;
                idx       <= last_elem ? '0 : idx + 1'b1;
                if (last_elem) begin
                    running <= 1'b0;
                end
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid && !running) begin
            divisor <= sum_value;
        end
        if (running && step >= STEP_LOAD && step < STEP_EMIT) begin
            rem <= rem_next;
            quo <= {quo[`SM_PW-2:0], q_bit};
        end
        if (running && step == STEP_LOAD) begin
            ovf <= (sum_t'(rd_data) >= divisor);
        end
        if (running && step == STEP_EMIT) begin
            out_index <= idx;
            out_prob  <= ovf ? '1 : quo;    // clip to 65535
        end
    end

endmodule

// File: hw/softmax_pkg.sv
// ******************************
// softmax shared data types
// ******************************

`include "softmax_settings.svh"

package softmax_pkg;

    // index into either memory
    typedef logic [`SM_AW-1:0] addr_t;

    // raw score from the host
    typedef logic signed [`SM_XW-1:0] sample_t;

    typedef logic [`SM_EW-1:0] exp_t;    // e^-d, Q0.16

    // wide enough for SM_N full-scale exponents
    typedef logic [`SM_SW-1:0] sum_t;

    typedef logic [`SM_PW-1:0] prob_t;   // Q0.16 output

endpackage

// File: hw/softmax_settings.svh
// ******************************
// softmax engine sizes
// batch, widths, divider timing
// ******************************

`ifndef SOFTMAX_SETTINGS_SVH
`define SOFTMAX_SETTINGS_SVH

`define SM_N            64          // samples per batch
`define SM_AW           6           // address width
`define SM_XW           8           // signed score width

`define SM_EW           16          // exponent, Q0.16
`define SM_SW           (`SM_EW + `SM_AW)
`define SM_PW           16          // probability, Q0.16

`define SM_DFRAC        4           // diff index d means d/16
`define SM_DIV_CYCLES   18          // read, 16 steps, emit

`endif

// File: hw/softmax_top.sv
// ******************************
// softmax engine top level
// two memories, three passes
// ******************************

`include "softmax_settings.svh"

module softmax_top import softmax_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    load_en,
    input  addr_t   load_addr,
    input  sample_t load_data,
    input  logic    start,
    output logic    busy,
    output logic    out_valid,
    output addr_t   out_index,
    output prob_t   out_prob,
    output logic    done
);

    logic [`SM_EW-1:0] smem_rd_a;
    logic [`SM_EW-1:0] smem_rd_b;
    addr_t             scan_addr;
    logic              max_valid;
    sample_t           max_value;
    addr_t             norm_rd_addr;
    logic              exp_wr_en;
    addr_t             exp_wr_addr;
    exp_t              exp_wr_data;
    logic              sum_valid;
    sum_t              sum_value;
    addr_t             div_rd_addr;
    exp_t              div_rd_data;
    logic              scan_active;
    logic              norm_active;
    logic              div_active;

    // scores kept sign extended, low byte read back as signed
    sample_ram u_sample_mem (
        .clk       (clk),
        .wr_en     (load_en),
        .wr_addr   (load_addr),
        .wr_data   ({{(`SM_EW - `SM_XW){load_data[`SM_XW-1]}}, load_data}),
        .rd_addr_a (scan_addr),
        .rd_data_a (smem_rd_a),
        .rd_addr_b (norm_rd_addr),
        .rd_data_b (smem_rd_b)
    );

    sample_ram u_exp_mem (
        .clk       (clk),
        .wr_en     (exp_wr_en),
        .wr_addr   (exp_wr_addr),
        .wr_data   (exp_wr_data),
        .rd_addr_a (div_rd_addr),
        .rd_data_a (div_rd_data),
        .rd_addr_b ('0),            // second read port not needed
        .rd_data_b ()
    );

    max_scan u_max_scan (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .pipe_busy (norm_active | div_active),
        .scan_addr (scan_addr),
        .scan_data (sample_t'(smem_rd_a[`SM_XW-1:0])),
        .active    (scan_active),
        .max_valid (max_valid),
        .max_value (max_value)
    );

    norm_exp_sum u_norm_exp_sum (
        .clk       (clk),
        .rst       (rst),
        .max_valid (max_valid),
        .max_value (max_value),
        .rd_addr   (norm_rd_addr),
        .rd_data   (sample_t'(smem_rd_b[`SM_XW-1:0])),
        .wr_en     (exp_wr_en),
        .wr_addr   (exp_wr_addr),
        .wr_data   (exp_wr_data),
        .active    (norm_active),
        .sum_valid (sum_valid),
        .sum_value (sum_value)
    );

    scale_div u_scale_div (
        .clk       (clk),
        .rst       (rst),
        .sum_valid (sum_valid),
        .sum_value (sum_value),
        .rd_addr   (div_rd_addr),
        .rd_data   (div_rd_data),
        .active    (div_active),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_prob  (out_prob),
        .done      (done)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= scan_active | norm_active | div_active;
        end
    end

endmodule

// File: list.f
+incdir+hw
hw/softmax_pkg.sv
hw/sample_ram.sv
hw/max_scan.sv
hw/exp_table.sv
hw/norm_exp_sum.sv
hw/scale_div.sv
hw/softmax_top.sv
bench/softmax_tb.sv
